//--- Makefile
TOP = gshareTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f verilog.f --top-module $(TOP) -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- src/branchIndex.sv
////////////////////////////////////////////////////////////
// gshare index formation
// keeps the global history of resolved branch outcomes and
// hashes it with the aligned pc to address the table
////////////////////////////////////////////////////////////

`default_nettype none

module branchIndex import indexPkg::*; #(
	parameter int indexBits = defaultIndexBits
) (
	input  logic                 clk,
	input  logic                 reset,
	input  pcAddr                pc,
	input  logic                 resolve,
	input  logic                 wasTaken,
	input  logic                 ready,
	output logic [indexBits-1:0] lookupIndex
);

	// most recent outcome sits in bit 0
	logic [indexBits-1:0] globalHistory;

	// pc bits just above the alignment offset
	logic [indexBits-1:0] pcBits;

	// history only moves on resolved branches
	// a resolve during the table sweep is dropped, same as the table write
	always_ff @(posedge clk) begin
		if (reset) begin
			globalHistory <= '0;
		end else if (resolve && ready) begin
			// oldest outcome falls off the top
			globalHistory <= {globalHistory[indexBits-2:0], wasTaken};
		end
	end

	// skip the alignment bits, they are always zero
	assign pcBits = pc[pcOffset +: indexBits];

	// gshare hash
	// a lookup in the same cycle as a resolve still sees the old history
	// since the register only updates on the edge
	assign lookupIndex = pcBits ^ globalHistory;

endmodule

`default_nettype wire

//--- src/counterPkg.sv
////////////////////////////////////////////////////////////
// 2-bit saturating counter definitions
// state encoding of each pattern table entry and the
// value every entry takes after the reset sweep
////////////////////////////////////////////////////////////

`default_nettype none

package counterPkg;

	// msb is the predicted direction
	// lsb is the hysteresis, it keeps one odd outcome from flipping the prediction
	typedef enum logic [1:0] {
		strongNotTaken = 2'd0,
		weakNotTaken   = 2'd1,
		weakTaken      = 2'd2,
		strongTaken    = 2'd3
	} counterState;

	// weakly not taken, so a single taken outcome is enough
	// to move a fresh entry towards taken
	localparam counterState counterResetState = weakNotTaken;

endpackage

`default_nettype wire

//--- src/counterUpdate.sv
////////////////////////////////////////////////////////////
// counter update for resolved branches
// saturating next state of the counter the prediction
// used, plus a registered misprediction flag
////////////////////////////////////////////////////////////

`default_nettype none

module counterUpdate import indexPkg::*, counterPkg::*; #(
	parameter int indexBits = defaultIndexBits
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        resolve,
	input  logic        ready,
	input  counterState resolveState,
	input  logic        wasTaken,
	output logic        writeEnable,
	output counterState newState,
	output logic        mispredict
);

	// history shifts by one bit, so the index needs at least two
	if (indexBits < 2) begin : gWidthCheck
		$error("indexBits must be at least 2");
	end

	// no write while the table is still being swept
	assign writeEnable = resolve && ready;

	// step towards the outcome, hold at either end
	always_comb begin
		case (resolveState)
			strongNotTaken: newState = wasTaken ? weakNotTaken : strongNotTaken;
			weakNotTaken:   newState = wasTaken ? weakTaken : strongNotTaken;
			weakTaken:      newState = wasTaken ? strongTaken : weakNotTaken;
			strongTaken:    newState = wasTaken ? strongTaken : weakTaken;
			default:        newState = counterResetState;
		endcase
	end

	// predicted direction was the msb of the state handed back
	always_ff @(posedge clk) begin
		if (reset)
			mispredict <= 1'b0;
		else
			mispredict <= writeEnable && (resolveState[1] != wasTaken);
	end

endmodule

`default_nettype wire

//--- src/gsharePredictor.sv
////////////////////////////////////////////////////////////
// gshare branch direction predictor
// lookup hashes pc with global history into the counter
// table, resolve steps the used counter and the history
////////////////////////////////////////////////////////////

`default_nettype none

module gsharePredictor import indexPkg::*, counterPkg::*; #(
	parameter int indexBits = defaultIndexBits
) (
	input  logic                 clk,
	input  logic                 reset,
	// lookup side
	input  logic                 lookup,
	input  pcAddr                pc,
	output logic                 predictValid,
	output logic                 predictTaken,
	output counterState          predictState,
	output logic [indexBits-1:0] predictIndex,
	// resolve side
	input  logic                 resolve,
	input  logic [indexBits-1:0] resolveIndex,
	input  counterState          resolveState,
	input  logic                 wasTaken,
	output logic                 mispredict,
	// high once the table sweep is done
	output logic                 ready
);

	// hashed address for this cycle's lookup
	logic [indexBits-1:0] lookupIndex;

	// update path into the table
	logic        writeEnable;
	counterState newState;

	// decode side, history and hash
	branchIndex #(
		.indexBits(indexBits)
	) indexGen (
		.clk        (clk),
		.reset      (reset),
		.pc         (pc),
		.resolve    (resolve),
		.wasTaken   (wasTaken),
		.ready      (ready),
		.lookupIndex(lookupIndex)
	);

	// counter memory, also owns ready
	patternTable #(
		.indexBits(indexBits)
	) pht (
		.clk         (clk),
		.reset       (reset),
		.lookup      (lookup),
		.lookupIndex (lookupIndex),
		.writeEnable (writeEnable),
		.resolveIndex(resolveIndex),
		.newState    (newState),
		.ready       (ready),
		.predictValid(predictValid),
		.predictTaken(predictTaken),
		.predictState(predictState),
		.predictIndex(predictIndex)
	);

	// execute side counter step
	counterUpdate #(
		.indexBits(indexBits)
	) update (
		.clk         (clk),
		.reset       (reset),
		.resolve     (resolve),
		.ready       (ready),
		.resolveState(resolveState),
		.wasTaken    (wasTaken),
		.writeEnable (writeEnable),
		.newState    (newState),
		.mispredict  (mispredict)
	);

endmodule

`default_nettype wire

//--- src/indexPkg.sv
////////////////////////////////////////////////////////////
// gshare index definitions
// program counter width, instruction alignment and the
// default width of the table index and global history
////////////////////////////////////////////////////////////

`default_nettype none

package indexPkg;

	// full program counter width
	localparam int pcWidth = 32;

	// instructions are word aligned, low bits carry no information
	localparam int pcOffset = 2;

	// index and history width unless the top level overrides it
	// 10 bits gives a 1024 entry table
	localparam int defaultIndexBits = 10;

	// one program counter word
	typedef logic [pcWidth-1:0] pcAddr;

endpackage

`default_nettype wire

//--- src/patternTable.sv
////////////////////////////////////////////////////////////
// pattern history table
// 2-bit counter memory with a reset sweep, one registered
// lookup read port and one write port for resolved branches
////////////////////////////////////////////////////////////

`default_nettype none

module patternTable import indexPkg::*, counterPkg::*; #(
	parameter int indexBits = defaultIndexBits
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 lookup,
	input  logic [indexBits-1:0] lookupIndex,
	input  logic                 writeEnable,
	input  logic [indexBits-1:0] resolveIndex,
	input  counterState          newState,
	output logic                 ready,
	output logic                 predictValid,
	output logic                 predictTaken,
	output counterState          predictState,
	output logic [indexBits-1:0] predictIndex
);

	localparam int tableDepth = 2 ** indexBits;

	// one counter per hashed index
	counterState phtMem [tableDepth];

	// walks every entry once after reset
	logic [indexBits-1:0] sweepIndex;

	// single write port shared by sweep and update
	logic                 memWrite;
	logic [indexBits-1:0] memAddr;
	counterState          memData;

	// sweep owns the port until ready
	assign memWrite = !ready || writeEnable;
	assign memAddr  = ready ? resolveIndex : sweepIndex;
	assign memData  = ready ? newState : counterResetState;

	// sweep control
	// ready goes high on the edge that writes the last entry
	always_ff @(posedge clk) begin
		if (reset) begin
			sweepIndex <= '0;
			ready      <= 1'b0;
		end else if (!ready) begin
			sweepIndex <= sweepIndex + 1'b1;
			if (sweepIndex == indexBits'(tableDepth - 1))
				ready <= 1'b1;
		end
	end

	// old entry is read on the same edge as any write, so read comes first
	always_ff @(posedge clk) begin
		if (memWrite)
			phtMem[memAddr] <= memData;
		predictState <= phtMem[lookupIndex];
		predictIndex <= lookupIndex;
	end

	// lookups before the sweep finishes get no answer
	always_ff @(posedge clk) begin
		if (reset)
			predictValid <= 1'b0;
		else
			predictValid <= lookup && ready;
	end

	// direction is the counter msb
	assign predictTaken = predictState[1];

endmodule

`default_nettype wire

//--- tests/clockGen.sv
////////////////////////////////////////////////////////////
// testbench clock and reset
// 100 ns clock, synchronous reset held for the first cycles
////////////////////////////////////////////////////////////

`default_nettype none

module clockGen #(
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ns;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// released on a rising edge like any other synchronous input
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/gshareTb.sv
////////////////////////////////////////////////////////////
// gshare predictor testbench
// directed tests plus random traffic, all predictions are
// checked against a reference table and history model
////////////////////////////////////////////////////////////

`default_nettype none

module gshareTb import indexPkg::*, counterPkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int tbIndexBits = defaultIndexBits;
	localparam int tableDepth  = 2 ** tbIndexBits;
	// cycle budget covers reset and sweep and the tests with some margin
	localparam int directedCycles = 200;
	localparam int randomCycles   = 400;
	localparam int cycleLimit = 5 + tableDepth + 2 + directedCycles + randomCycles + 100;

	logic                   clk;
	logic                   reset;
	logic                   lookup;
	pcAddr                  pc;
	logic                   resolve;
	logic [tbIndexBits-1:0] resolveIndex;
	counterState            resolveState;
	logic                   wasTaken;
	logic                   predictValid;
	logic                   predictTaken;
	counterState            predictState;
	logic [tbIndexBits-1:0] predictIndex;
	logic                   mispredict;
	logic                   ready;

	// reference model of the table and the global history
	counterState            refTable [tableDepth];
	logic [tbIndexBits-1:0] refHistory;
	// what the outputs must show after the next edge
	logic                   expValid;
	counterState            expState;
	logic [tbIndexBits-1:0] expIndex;
	logic                   expMiss;
	// predictions handed out and not yet resolved
	logic [tbIndexBits-1:0] flightIndex [$];
	counterState            flightState [$];
	int                     cycleCount = 0;

	clockGen #(.resetCycles(5)) clocks (.clk(clk), .reset(reset));

	gsharePredictor #(.indexBits(tbIndexBits)) uut (
		.clk(clk), .reset(reset), .lookup(lookup), .pc(pc),
		.predictValid(predictValid), .predictTaken(predictTaken),
		.predictState(predictState), .predictIndex(predictIndex),
		.resolve(resolve), .resolveIndex(resolveIndex), .resolveState(resolveState),
		.wasTaken(wasTaken), .mispredict(mispredict), .ready(ready)
	);

	bind gsharePredictor gshare_assert assertions (
		.clk(clk), .reset(reset), .lookup(lookup), .resolve(resolve), .ready(ready),
		.predictValid(predictValid), .predictTaken(predictTaken),
		.predictState(predictState), .mispredict(mispredict)
	);

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compareState(input string name, input counterState got, input counterState exp);
		if (got !== exp)
			reportFailure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic compareIndex(input string name, input logic [tbIndexBits-1:0] got,
			input logic [tbIndexBits-1:0] exp);
		if (got !== exp)
			reportFailure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic compareFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			reportFailure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// saturating step goes up on taken and down on not taken
	function automatic counterState stepCounter(input counterState s, input logic taken);
		if (taken)
			return (s == strongTaken) ? strongTaken : counterState'(s + 2'd1);
		return (s == strongNotTaken) ? strongNotTaken : counterState'(s - 2'd1);
	endfunction

	task automatic checkPending();
		if (expValid) begin
			compareFlag("predictValid", predictValid, 1'b1);
			compareIndex("predictIndex", predictIndex, expIndex);
			compareState("predictState", predictState, expState);
			compareFlag("predictTaken", predictTaken, expState[1]);
		end else begin
			compareFlag("predictValid", predictValid, 1'b0);
		end
		compareFlag("mispredict", mispredict, expMiss);
	endtask

	// drive one clock of stimulus and check the previous cycle's results at the falling edge
	task automatic driveCycle(input logic lk, input pcAddr p, input logic rs,
			input logic [tbIndexBits-1:0] ri, input counterState rst, input logic wt);
		logic [tbIndexBits-1:0] hashed;
		@(posedge clk);
		lookup       <= lk;
		pc           <= p;
		resolve      <= rs;
		resolveIndex <= ri;
		resolveState <= rst;
		wasTaken     <= wt;
		@(negedge clk);
		checkPending();
		// lookup sees old history and old entry
		hashed   = p[pcOffset +: tbIndexBits] ^ refHistory;
		expValid = lk && ready;
		if (expValid) begin
			expState = refTable[hashed];
			expIndex = hashed;
			flightIndex.push_back(hashed);
			flightState.push_back(refTable[hashed]);
		end
		expMiss = rs && ready && (rst[1] != wt);
		if (rs && ready) begin
			refTable[ri] = stepCounter(rst, wt);
			refHistory   = {refHistory[tbIndexBits-2:0], wt};
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) driveCycle(1'b0, '0, 1'b0, '0, strongNotTaken, 1'b0);
	endtask

	// lookup a pc that hashes to target with the current history
	task automatic probeIndex(input logic [tbIndexBits-1:0] target);
		pcAddr p;
		p = pcAddr'(target ^ refHistory) << pcOffset;
		driveCycle(1'b1, p, 1'b0, '0, strongNotTaken, 1'b0);
		idleCycles(1);
	endtask

	task automatic testResetAndSweep();
		int waitCycles;
		waitCycles = 0;
		@(negedge clk);
		while (reset) begin
			compareFlag("ready", ready, 1'b0);
			compareFlag("predictValid", predictValid, 1'b0);
			compareFlag("mispredict", mispredict, 1'b0);
			@(negedge clk);
		end
		// lookups and resolves during the sweep must be dropped
		// a stray taken resolve on a weak not taken entry 0 would show up
		// in the history, in entry 0 and on mispredict
		// resolves stop halfway so the cycle where ready rises stays idle
		while (!ready) begin
			driveCycle(1'b1, $urandom(), (waitCycles < tableDepth / 2) && waitCycles[0], '0,
				weakNotTaken, 1'b1);
			waitCycles++;
			if (waitCycles > tableDepth + 2)
				reportFailure("ready did not rise within the table depth plus 2 cycles");
		end
		// pc 0x1000 hashes to entry 0 where the dropped resolves were aimed
		driveCycle(1'b1, 32'h0000_1000, 1'b0, '0, strongNotTaken, 1'b0);
		driveCycle(1'b1, 32'h0000_0abc, 1'b0, '0, strongNotTaken, 1'b0);
		idleCycles(1);
		compareState("predictState", predictState, weakNotTaken);
		compareFlag("predictTaken", predictTaken, 1'b0);
	endtask

	task automatic testIndexHash();
		pcAddr p;
		p = 32'h0000_1234;
		driveCycle(1'b1, p, 1'b0, '0, strongNotTaken, 1'b0);
		idleCycles(1);
		compareIndex("predictIndex", predictIndex, p[pcOffset +: tbIndexBits]);
		// outcomes 1 0 1 1 with the oldest ending up highest
		driveCycle(1'b0, '0, 1'b1, 10'h005, refTable[5], 1'b1);
		driveCycle(1'b0, '0, 1'b1, 10'h005, refTable[5], 1'b0);
		driveCycle(1'b0, '0, 1'b1, 10'h005, refTable[5], 1'b1);
		driveCycle(1'b0, '0, 1'b1, 10'h005, refTable[5], 1'b1);
		driveCycle(1'b1, p, 1'b0, '0, strongNotTaken, 1'b0);
		idleCycles(1);
		compareIndex("predictIndex", predictIndex,
			p[pcOffset +: tbIndexBits] ^ tbIndexBits'(4'b1011));
	endtask

	task automatic testSaturation();
		logic [tbIndexBits-1:0] target;
		target = 10'h2a5;
		repeat (4) begin
			probeIndex(target);
			driveCycle(1'b0, '0, 1'b1, target, refTable[target], 1'b1);
		end
		probeIndex(target);
		compareIndex("predictIndex", predictIndex, target);
		compareState("predictState", predictState, strongTaken);
		repeat (4) begin
			probeIndex(target);
			driveCycle(1'b0, '0, 1'b1, target, refTable[target], 1'b0);
		end
		probeIndex(target);
		compareState("predictState", predictState, strongNotTaken);
	endtask

	task automatic testMispredict();
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 2; t++) begin
				driveCycle(1'b0, '0, 1'b1, 10'h0c3, counterState'(s[1:0]), t[0]);
				idleCycles(1);
				compareFlag("mispredict", mispredict, s[1] ^ t[0]);
				// single cycle pulse
				idleCycles(1);
				compareFlag("mispredict", mispredict, 1'b0);
			end
		end
	endtask

	task automatic testRandomTraffic();
		logic                   lk;
		logic                   rs;
		logic [tbIndexBits-1:0] ri;
		counterState            rst;
		flightIndex.delete();
		flightState.delete();
		for (int i = 0; i < randomCycles; i++) begin
			lk  = $urandom_range(0, 9) < 6;
			// keep several predictions in flight and force a resolve when there are too many
			rs  = (flightIndex.size() > 0) &&
				((flightIndex.size() > 6) || ($urandom_range(0, 2) == 0));
			ri  = '0;
			rst = strongNotTaken;
			if (rs) begin
				ri  = flightIndex.pop_front();
				rst = flightState.pop_front();
			end
			driveCycle(lk, $urandom(), rs, ri, rst, $urandom_range(0, 1) == 1);
		end
		// return what is still outstanding
		while (flightIndex.size() > 0) begin
			ri  = flightIndex.pop_front();
			rst = flightState.pop_front();
			driveCycle(1'b0, '0, 1'b1, ri, rst, $urandom_range(0, 1) == 1);
		end
		idleCycles(2);
	endtask

	// watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			reportFailure($sformatf("simulation timed out after %0d cycles", cycleCount));
	end

	initial begin
		void'($urandom(72));
		lookup       <= 1'b0;
		pc           <= '0;
		resolve      <= 1'b0;
		resolveIndex <= '0;
		resolveState <= strongNotTaken;
		wasTaken     <= 1'b0;
		foreach (refTable[i])
			refTable[i] = counterResetState;
		refHistory = '0;
		expValid   = 1'b0;
		expState   = counterResetState;
		expIndex   = '0;
		expMiss    = 1'b0;
		testResetAndSweep();
		testIndexHash();
		testSaturation();
		testMispredict();
		testRandomTraffic();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/gshare_assert.sv
////////////////////////////////////////////////////////////
// predictor control assertions
// bound to the top level, checks the output pulses against
// the strobes that cause them and the ready level
////////////////////////////////////////////////////////////

`default_nettype none

module gshare_assert import counterPkg::*; (
	input logic        clk,
	input logic        reset,
	input logic        lookup,
	input logic        resolve,
	input logic        ready,
	input logic        predictValid,
	input logic        predictTaken,
	input counterState predictState,
	input logic        mispredict
);

	timeunit 1ns;
	timeprecision 1ns;

	// a prediction needs a lookup accepted on the edge before
	validFollowsLookup: assert property (@(posedge clk) disable iff (reset)
		predictValid |-> $past(lookup && ready))
		else $error("predictValid without a lookup made while ready");

	mispredictFollowsResolve: assert property (@(posedge clk) disable iff (reset)
		mispredict |-> $past(resolve))
		else $error("mispredict without a resolve on the edge before");

	// direction is the counter msb
	takenMatchesState: assert property (@(posedge clk) disable iff (reset)
		predictValid |-> (predictTaken == predictState[1]))
		else $error("predictTaken differs from the msb of predictState");

	// once the sweep is done only reset clears ready
	readyHolds: assert property (@(posedge clk) disable iff (reset)
		$fell(ready) |-> $past(reset))
		else $error("ready fell without reset");

endmodule

`default_nettype wire

//--- verilog.f
src/indexPkg.sv
src/counterPkg.sv
src/branchIndex.sv
src/patternTable.sv
src/counterUpdate.sv
src/gsharePredictor.sv
tests/clockGen.sv
tests/gshare_assert.sv
tests/gshareTb.sv
